// File: nnPkg.sv
package nnPkg;

	// ============================================================
	// Word type and layer sizes
	// ============================================================
	localparam int DataWidth = 32;
	localparam int NumFeatures = 15;
	localparam int NumHidden = 4;
	localparam int NumClasses = 3;
	localparam int ClassIdxWidth = $clog2(NumClasses);
	localparam int LayerLatency = 3; // Input, sum and ReLU stages.

	typedef logic [DataWidth-1:0] word_t; // Two's complement.

	typedef struct packed {
		logic [ClassIdxWidth-1:0] classIdx;
		word_t score;
	} classResult_t;

	// ============================================================
	// Hidden layer constants
	// ============================================================
	// Element i of row n multiplies feature i in hidden neuron n.
	localparam word_t [0:NumHidden-1][0:NumFeatures-1] HiddenWeights = '{
		'{ 139, 1107, 2357, -3670, 1138, 2341, -1254, -3157,
			-7633, 3206, 5052, -3168, -2939, 6275, 2352 },
		'{ -2210, 845, 3912, 1476, -5120, 733, 2688, -1893,
			4410, -967, 1502, 3384, -2745, 619, -4061 },
		'{ 3027, -1648, -712, 5289, 2266, -3941, 1873, 4127,
			-1095, -2583, 776, -6012, 3458, 1219, -937 },
		'{ -1344, 2901, -4478, 862, 3315, 1587, -2269, 5736,
			2044, -3389, -1176, 2613, 4892, -3050, 1431 }
	};

	localparam word_t [0:NumHidden-1] HiddenBias = '{ 301, -512, 1024, -77 };

	// ============================================================
	// Output layer constants
	// ============================================================
	localparam word_t [0:NumClasses-1][0:NumHidden-1] OutputWeights = '{
		'{ 3, -2, 5, 1 },
		'{ -4, 6, -1, 2 },
		'{ 2, 1, -3, 4 }
	};

	localparam word_t [0:NumClasses-1] OutputBias = '{ 16, -8, 0 };

endpackage

// File: neuronNode.sv
`timescale 1ns/1ps

module neuronNode #(
	parameter int NumInputs = 15,
	parameter nnPkg::word_t [0:NumInputs-1] Weights = '0,
	parameter nnPkg::word_t Bias = '0
) (
	input logic clk,
	input logic reset,
	input nnPkg::word_t [NumInputs-1:0] inputs,
	output nnPkg::word_t activation
);

	nnPkg::word_t [NumInputs-1:0] inputsReg; // Stage 1.
	nnPkg::word_t weightedSum;
	nnPkg::word_t sumReg; // Stage 2.

	// ============================================================
	// Multiply and accumulate
	// ============================================================
	// All products and additions wrap at 32 bits.
	always_comb
	begin
		weightedSum = Bias;
		for (int i = 0; i < NumInputs; i++)
		begin
			weightedSum = weightedSum + inputsReg[i] * Weights[i];
		end
	end

	// ============================================================
	// Pipeline registers
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputsReg <= '0;
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			inputsReg <= inputs;
			sumReg <= weightedSum;
			if (sumReg[nnPkg::DataWidth-1])
			begin
				activation <= '0; // Negative sum clamps.
			end
			else
			begin
				activation <= sumReg;
			end
		end
	end

endmodule

// File: denseLayer.sv
`timescale 1ns/1ps

module denseLayer #(
	parameter int NumInputs = 15,
	parameter int NumNeurons = 4,
	parameter nnPkg::word_t [0:NumNeurons-1][0:NumInputs-1] Weights = '0,
	parameter nnPkg::word_t [0:NumNeurons-1] Biases = '0
) (
	input logic clk,
	input logic reset,
	input nnPkg::word_t [NumInputs-1:0] inputs,
	output nnPkg::word_t [NumNeurons-1:0] activations
);

	// ============================================================
	// Neuron row
	// ============================================================
	// Every neuron sees the same input vector with its own weights.
	for (genvar n = 0; n < NumNeurons; n++)
	begin : gNeuron
		neuronNode #(
			.NumInputs(NumInputs),
			.Weights(Weights[n]), // Row n of the matrix.
			.Bias(Biases[n])
		) uNeuron (
			.clk(clk),
			.reset(reset),
			.inputs(inputs),
			.activation(activations[n])
		);
	end

endmodule

// File: argmaxSelect.sv
`timescale 1ns/1ps

module argmaxSelect #(
	parameter int NumValues = 3,
	parameter int IdxWidth = 2
) (
	input logic clk,
	input logic reset,
	input nnPkg::word_t [NumValues-1:0] values,
	output nnPkg::classResult_t result
);

	logic [IdxWidth-1:0] bestIdx;
	nnPkg::word_t bestValue;

	// Values come from ReLU, so an unsigned compare is enough.
	always_comb
	begin
		bestIdx = '0;
		bestValue = values[0];
		for (int i = 1; i < NumValues; i++)
		begin
			if (values[i] > bestValue) // Strict compare keeps ties at the lowest index.
			begin
				bestIdx = i[IdxWidth-1:0];
				bestValue = values[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else
		begin
			result.classIdx <= bestIdx;
			result.score <= bestValue;
		end
	end

endmodule

// File: mlpClassifier.sv
`timescale 1ns/1ps

module mlpClassifier (
	input logic clk,
	input logic reset,
	input nnPkg::word_t [nnPkg::NumFeatures-1:0] features,
	output nnPkg::classResult_t result
);

	nnPkg::word_t [nnPkg::NumHidden-1:0] hiddenAct;
	nnPkg::word_t [nnPkg::NumClasses-1:0] classAct;

	// ============================================================
	// Dense layers
	// ============================================================
	denseLayer #(
		.NumInputs(nnPkg::NumFeatures),
		.NumNeurons(nnPkg::NumHidden),
		.Weights(nnPkg::HiddenWeights),
		.Biases(nnPkg::HiddenBias)
	) uHiddenLayer (
		.clk(clk),
		.reset(reset),
		.inputs(features),
		.activations(hiddenAct)
	);

	denseLayer #(
		.NumInputs(nnPkg::NumHidden),
		.NumNeurons(nnPkg::NumClasses),
		.Weights(nnPkg::OutputWeights),
		.Biases(nnPkg::OutputBias)
	) uOutputLayer (
		.clk(clk),
		.reset(reset),
		.inputs(hiddenAct),
		.activations(classAct)
	);

	// ============================================================
	// Class decision
	// ============================================================
	argmaxSelect #(
		.NumValues(nnPkg::NumClasses),
		.IdxWidth(nnPkg::ClassIdxWidth)
	) uArgmax (
		.clk(clk),
		.reset(reset),
		.values(classAct),
		.result(result)
	);

endmodule

// File: tbModel.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ============================================================
// Random source
// ============================================================
function automatic nnPkg::word_t lcgNext(input nnPkg::word_t state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

// ============================================================
// Reference model
// ============================================================
// Same wrapping arithmetic as the RTL neuron.
function automatic nnPkg::word_t modelNeuron(
	input nnPkg::word_t inputs [$],
	input nnPkg::word_t weights [$],
	input nnPkg::word_t bias,
	input bit applyRelu
);
	nnPkg::word_t sum;
	sum = bias;
	foreach (inputs[i])
	begin
		sum = sum + inputs[i] * weights[i];
	end
	if (applyRelu && sum[nnPkg::DataWidth-1])
	begin
		sum = '0;
	end
	return sum;
endfunction

function automatic void modelHiddenLayer(
	input nnPkg::word_t [nnPkg::NumFeatures-1:0] features,
	input bit applyRelu,
	output nnPkg::word_t [nnPkg::NumHidden-1:0] hidden
);
	nnPkg::word_t inputs [$];
	nnPkg::word_t weights [$];
	for (int i = 0; i < nnPkg::NumFeatures; i++)
	begin
		inputs.push_back(features[i]);
	end
	for (int n = 0; n < nnPkg::NumHidden; n++)
	begin
		weights.delete();
		for (int i = 0; i < nnPkg::NumFeatures; i++)
		begin
			weights.push_back(nnPkg::HiddenWeights[n][i]);
		end
		hidden[n] = modelNeuron(inputs, weights, nnPkg::HiddenBias[n], applyRelu);
	end
endfunction

function automatic void modelOutputLayer(
	input nnPkg::word_t [nnPkg::NumHidden-1:0] hidden,
	output nnPkg::word_t [nnPkg::NumClasses-1:0] classes
);
	nnPkg::word_t inputs [$];
	nnPkg::word_t weights [$];
	for (int i = 0; i < nnPkg::NumHidden; i++)
	begin
		inputs.push_back(hidden[i]);
	end
	for (int n = 0; n < nnPkg::NumClasses; n++)
	begin
		weights.delete();
		for (int i = 0; i < nnPkg::NumHidden; i++)
		begin
			weights.push_back(nnPkg::OutputWeights[n][i]);
		end
		classes[n] = modelNeuron(inputs, weights, nnPkg::OutputBias[n], 1'b1);
	end
endfunction

// Lowest index wins on equal maxima.
function automatic nnPkg::classResult_t modelArgmax(
	input nnPkg::word_t [nnPkg::NumClasses-1:0] values
);
	nnPkg::classResult_t best;
	best.classIdx = '0;
	best.score = values[0];
	for (int c = 1; c < nnPkg::NumClasses; c++)
	begin
		if (values[c] > best.score)
		begin
			best.classIdx = c[nnPkg::ClassIdxWidth-1:0];
			best.score = values[c];
		end
	end
	return best;
endfunction

function automatic nnPkg::classResult_t modelClassify(
	input nnPkg::word_t [nnPkg::NumFeatures-1:0] features
);
	nnPkg::word_t [nnPkg::NumHidden-1:0] hidden;
	nnPkg::word_t [nnPkg::NumClasses-1:0] classes;
	modelHiddenLayer(features, 1'b1, hidden);
	modelOutputLayer(hidden, classes);
	return modelArgmax(classes);
endfunction

`endif

// File: tb_mlpClassifier.sv
`timescale 1ns/1ps

module tb_mlpClassifier;

	// Three stages per dense layer plus the argmax register.
	localparam int ResultDelay = 2 * nnPkg::LayerLatency + 1;
	localparam int DrainLimit = ResultDelay + 4;
	localparam int TieSearchLimit = 2000;
	localparam int StreamLength = 200;

	typedef nnPkg::word_t [nnPkg::NumFeatures-1:0] featureVec_t;
	typedef nnPkg::word_t [nnPkg::NumHidden-1:0] hiddenVec_t;
	typedef nnPkg::word_t [nnPkg::NumClasses-1:0] classVec_t;

	typedef struct packed {
		int dueCycle;
		nnPkg::classResult_t expected;
	} expectEntry_t;

	logic clk;
	logic reset;
	featureVec_t features;
	nnPkg::classResult_t result;

	expectEntry_t pending [$]; // Expected results still in flight.
	nnPkg::word_t rngState;
	string currentTest;
	int cycleCount;
	int resetAge; // Edges since reset was last sampled high.

	`include "tbModel.svh"

	mlpClassifier u_dut (
		.clk(clk),
		.reset(reset),
		.features(features),
		.result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period.
	end

	// ============================================================
	// Checking
	// ============================================================
	task automatic failRun();
		$display("tests failed");
		$fatal(1, "Simulation stopped on first failure.");
	endtask

	task automatic reportMismatch(input string testName, input nnPkg::classResult_t expected);
		$display("Error: %s expected class %0d score %0d, actual class %0d score %0d",
			testName, expected.classIdx, expected.score, result.classIdx, result.score);
		failRun();
	endtask

	task automatic compareResult(input string testName, input nnPkg::classResult_t expected);
		assert (result === expected)
		else
		begin
			reportMismatch(testName, expected);
		end
	endtask

	// Advance one clock and check whatever is due now.
	task automatic stepCycle();
		expectEntry_t entry;
		@(posedge clk);
		#1;
		cycleCount++;
		if (reset)
		begin
			resetAge = 0;
		end
		else if (resetAge < 2)
		begin
			resetAge++;
		end
		// Cleared on the reset edge and still clear one edge later.
		if (resetAge <= 1)
		begin
			compareResult("resetState", '0);
		end
		while (pending.size() > 0 && pending[0].dueCycle <= cycleCount)
		begin
			entry = pending.pop_front();
			compareResult(currentTest, entry.expected);
		end
	endtask

	// ============================================================
	// Stimulus
	// ============================================================
	task automatic applyVector(input featureVec_t vec);
		expectEntry_t entry;
		stepCycle();
		features = vec;
		if (!reset)
		begin
			entry.dueCycle = cycleCount + ResultDelay;
			entry.expected = modelClassify(vec);
			pending.push_back(entry);
		end
	endtask

	task automatic holdReset(input int cycles);
		reset = 1'b1;
		features = '0;
		pending.delete(); // In-flight vectors are lost.
		for (int i = 0; i < cycles; i++)
		begin
			stepCycle();
		end
		reset = 1'b0;
	endtask

	task automatic drainResults();
		int waited;
		waited = 0;
		while (pending.size() > 0 && waited < DrainLimit)
		begin
			stepCycle();
			waited++;
		end
		if (pending.size() > 0)
		begin
			$display("Timed out in %s waiting for %0d pending results", currentTest,
				pending.size());
			failRun();
		end
	endtask

	task automatic randomFeatures(input bit wide, output featureVec_t vec);
		for (int i = 0; i < nnPkg::NumFeatures; i++)
		begin
			rngState = lcgNext(rngState);
			if (wide)
			begin
				vec[i] = rngState;
			end
			else
			begin
				vec[i] = $signed(rngState) >>> 18; // Roughly +-8192.
			end
		end
	endtask

	// ============================================================
	// Test sequences
	// ============================================================
	task automatic singleVectorLatency();
		featureVec_t vec;
		currentTest = "singleVector";
		for (int i = 0; i < nnPkg::NumFeatures; i++)
		begin
			vec[i] = i * 211 - 1200;
		end
		applyVector(vec);
		for (int i = 0; i < ResultDelay; i++)
		begin
			applyVector('0);
		end
		drainResults();
	endtask

	task automatic streamRandomVectors();
		featureVec_t vec;
		currentTest = "streaming";
		for (int v = 0; v < StreamLength; v++)
		begin
			randomFeatures(v[0], vec);
			applyVector(vec);
		end
		drainResults();
	endtask

	task automatic clampNegativeHidden();
		featureVec_t vec;
		hiddenVec_t rawHidden;
		classVec_t rawClasses;
		int differing;
		currentTest = "reluClamp";
		differing = 0;
		for (int n = 0; n < nnPkg::NumHidden; n++)
		begin
			// Large inputs only where neuron n has negative weights.
			for (int i = 0; i < nnPkg::NumFeatures; i++)
			begin
				if (nnPkg::HiddenWeights[n][i][nnPkg::DataWidth-1])
				begin
					vec[i] = 32'd20000;
				end
				else
				begin
					vec[i] = '0;
				end
			end
			modelHiddenLayer(vec, 1'b0, rawHidden);
			assert (rawHidden[n][nnPkg::DataWidth-1])
			else
			begin
				$display("Hidden neuron %0d sum is not negative for its clamp vector", n);
				failRun();
			end
			modelOutputLayer(rawHidden, rawClasses);
			if (modelArgmax(rawClasses) != modelClassify(vec))
			begin
				differing++;
			end
			applyVector(vec);
		end
		drainResults();
		assert (differing > 0)
		else
		begin
			$display("No clamp vector changed the result compared with unclamped hidden sums");
			failRun();
		end
	endtask

	task automatic tieBreakLowestIndex();
		featureVec_t vec;
		hiddenVec_t hidden;
		classVec_t classes;
		int attempts;
		bit found;
		currentTest = "tieRule";
		attempts = 0;
		found = 1'b0;
		// Wide inputs wrap the output sums, so some vector clamps all three.
		while (!found && attempts < TieSearchLimit)
		begin
			randomFeatures(1'b1, vec);
			modelHiddenLayer(vec, 1'b1, hidden);
			modelOutputLayer(hidden, classes);
			found = (classes == '0);
			attempts++;
		end
		if (!found)
		begin
			$display("No vector found that drives every output neuron to zero");
			failRun();
		end
		applyVector(vec);
		applyVector('0);
		drainResults();
	endtask

	task automatic resetDuringStream();
		featureVec_t vec;
		currentTest = "resetMidStream";
		for (int v = 0; v < 20; v++)
		begin
			randomFeatures(1'b0, vec);
			applyVector(vec);
		end
		holdReset(2);
		for (int v = 0; v < 20; v++)
		begin
			randomFeatures(1'b0, vec);
			applyVector(vec);
		end
		drainResults();
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial
	begin
		reset = 1'b1;
		features = '0;
		rngState = 32'h3cbf;
		cycleCount = 0;
		resetAge = 0;
		currentTest = "resetState";
		holdReset(16);
		singleVectorLatency();
		streamRandomVectors();
		clampNegativeHidden();
		tieBreakLowestIndex();
		resetDuringStream();
		$display("all tests passed");
		$finish;
	end

endmodule

// File: files.f
+incdir+.
nnPkg.sv
neuronNode.sv
denseLayer.sv
argmaxSelect.sv
mlpClassifier.sv
tb_mlpClassifier.sv

// File: run.sh
#!/bin/sh
# Build and run the MLP classifier testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
	-f files.f \
	--top-module tb_mlpClassifier \
	-o simMlp
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

simOutput=$(./obj_dir/simMlp 2>&1)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOutput" | grep -qx "all tests passed"; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1
